// File: Makefile
VERILATOR ?= verilator
TOP       ?= iadc_tb
FILELIST  ?= iadc_controller.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: capture/iadc_capture.sv
`timescale 1ns/1ps

module iadc_capture
  import iadc_sample_pkg::*;
(
  input  logic      adc_clk_0_i,
  input  logic      adc_clk_90_i,
  input  logic      wb_rst_i,
  input  adc_data_t adc_data_i,
  input  adc_oor_t  adc_oor_i,
  input  logic      adc_sync_i,
  input  logic      enable_i,     // from the wishbone domain
  output logic      wr_en_o,
  output sample_t   wr_data_o
);

  adc_sync_t sync_q;
  logic      sync_p0;
  logic      sync_p90;
  logic      sync_p180;
  logic      sync_p270;
  logic      rst_meta;
  logic      rst_q;
  logic      en_meta;

  // sync seen on all four clock phases
  always_ff @(posedge adc_clk_0_i)  sync_p0   <= adc_sync_i;
  always_ff @(posedge adc_clk_90_i) sync_p90  <= adc_sync_i;
  always_ff @(negedge adc_clk_0_i)  sync_p180 <= adc_sync_i;
  always_ff @(negedge adc_clk_90_i) sync_p270 <= adc_sync_i;

  assign sync_q = {sync_p270, sync_p180, sync_p90, sync_p0};

  always_ff @(posedge adc_clk_0_i) begin
    wr_data_o <= {sync_q, adc_oor_i, adc_data_i};
  end

  // local copy of the bus reset
  always_ff @(posedge adc_clk_0_i) begin
    rst_meta <= wb_rst_i;
    rst_q    <= rst_meta;
  end

  // two-flop enable synchronizer, second stage is the write enable
  always_ff @(posedge adc_clk_0_i) begin
    if (rst_q) begin
      en_meta <= 1'b0;
      wr_en_o <= 1'b0;
    end else begin
      en_meta <= enable_i;
      wr_en_o <= en_meta;
    end
  end

endmodule

// File: capture/iadc_sample_fifo.sv
`timescale 1ns/1ps

module iadc_sample_fifo
  import iadc_reg_pkg::*;
  import iadc_sample_pkg::*;
#(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic         wr_clk_i,
  input  logic         wr_rst_i,
  input  logic         wr_en_i,
  input  sample_t      wr_data_i,
  input  logic         rd_clk_i,
  input  logic         rd_rst_i,
  input  logic         rd_en_i,
  input  logic         flush_i,
  output sample_t      rd_data_o,    // head word, valid unless empty
  output fifo_status_t status_o
);

  localparam int DEPTH = 2 ** FIFO_ADDR_W;

  typedef logic [FIFO_ADDR_W:0] ptr_t;   // extra msb tells full from empty

  sample_t mem [DEPTH];

  ptr_t wr_bin, wr_bin_next, wr_gray;
  ptr_t rd_gray_meta, rd_gray_sync, rd_bin_at_wr;
  ptr_t rd_bin, rd_bin_next, rd_gray;
  ptr_t wr_gray_meta, wr_gray_sync, wr_bin_at_rd;
  ptr_t rd_count;
  logic wr_full;
  logic rd_empty;

  function automatic ptr_t gray2bin(ptr_t g);
    ptr_t b;
    b[FIFO_ADDR_W] = g[FIFO_ADDR_W];
    for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
      b[i] = b[i + 1] ^ g[i];
    end
    return b;
  endfunction

  // write side
  assign wr_bin_next  = wr_bin + 1'b1;
  assign rd_bin_at_wr = gray2bin(rd_gray_sync);
  assign wr_full      = (wr_bin[FIFO_ADDR_W] != rd_bin_at_wr[FIFO_ADDR_W]) &&
                        (wr_bin[FIFO_ADDR_W-1:0] == rd_bin_at_wr[FIFO_ADDR_W-1:0]);

  always_ff @(posedge wr_clk_i) begin
    if (wr_rst_i) begin
      wr_bin       <= '0;
      wr_gray      <= '0;
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
      if (wr_en_i && !wr_full) begin   // sample lost when full
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_en_i && !wr_full) mem[wr_bin[FIFO_ADDR_W-1:0]] <= wr_data_i;
  end

  // read side
  assign rd_bin_next  = rd_bin + 1'b1;
  assign wr_bin_at_rd = gray2bin(wr_gray_sync);
  assign rd_count     = wr_bin_at_rd - rd_bin;
  assign rd_empty     = (rd_count == '0);

  always_ff @(posedge rd_clk_i) begin
    if (rd_rst_i) begin
      rd_bin       <= '0;
      rd_gray      <= '0;
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
      if (flush_i) begin
        // drop everything seen so far
        rd_bin  <= wr_bin_at_rd;
        rd_gray <= wr_gray_sync;
      end else if (rd_en_i && !rd_empty) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

  assign rd_data_o = mem[rd_bin[FIFO_ADDR_W-1:0]];

  assign status_o = {rd_count == ptr_t'(DEPTH),
                     rd_count >= ptr_t'(DEPTH - 1),
                     rd_count <= ptr_t'(1),
                     rd_empty};

endmodule

// File: common/iadc_reg_pkg.sv
package iadc_reg_pkg;

  // wishbone side
  typedef logic [15:0] wb_data_t;
  typedef logic [1:0]  wb_sel_t;
  typedef logic [3:0]  reg_idx_t;      // taken from adr[4:1]

  // three-wire configuration link
  typedef logic [2:0]  twi_addr_t;
  typedef logic [15:0] twi_data_t;

  localparam int TWI_FRAME_W = $bits(twi_addr_t) + $bits(twi_data_t);

  // {full, almost_full, almost_empty, empty}
  typedef logic [3:0]  fifo_status_t;

  // control registers
  localparam reg_idx_t REG_RESET       = 4'd0;
  localparam reg_idx_t REG_MODE        = 4'd1;
  localparam reg_idx_t REG_TWI_ADDR    = 4'd2;
  localparam reg_idx_t REG_TWI_DATA    = 4'd3;
  localparam reg_idx_t REG_TWI_TX      = 4'd4;

  // sample windows, most significant first
  localparam reg_idx_t REG_FIFODATA_4  = 4'd5;
  localparam reg_idx_t REG_FIFODATA_3  = 4'd6;
  localparam reg_idx_t REG_FIFODATA_2  = 4'd7;
  localparam reg_idx_t REG_FIFODATA_1  = 4'd8;
  localparam reg_idx_t REG_FIFODATA_0  = 4'd9;

  // fifo control
  localparam reg_idx_t REG_FIFO_ADV    = 4'd10;
  localparam reg_idx_t REG_FIFO_STATUS = 4'd11;
  localparam reg_idx_t REG_FIFO_CTRL   = 4'd12;

endpackage

// File: common/iadc_sample_pkg.sv
package iadc_sample_pkg;

  localparam int ADC_DATA_W = 64;   // 2 channels x 4 interleaved x 8 bit
  localparam int ADC_OOR_W  = 4;
  localparam int ADC_SYNC_W = 4;    // one bit per clock phase

  localparam int SAMPLE_W   = ADC_SYNC_W + ADC_OOR_W + ADC_DATA_W;

  // [ch1:3 ch1:2 ch1:1 ch1:0 ch0:3 ch0:2 ch0:1 ch0:0]
  typedef logic [ADC_DATA_W-1:0] adc_data_t;
  typedef logic [ADC_OOR_W-1:0]  adc_oor_t;
  typedef logic [ADC_SYNC_W-1:0] adc_sync_t;

  // packed as {sync, oor, data}
  typedef logic [SAMPLE_W-1:0]   sample_t;

endpackage

// File: hdl/iadc_controller.sv
`timescale 1ns/1ps

module iadc_controller
  import iadc_reg_pkg::*;
  import iadc_sample_pkg::*;
#(
  parameter int TWI_DIV_W   = 7,
  parameter int FIFO_ADDR_W = 4
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  wb_sel_t     wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  wb_data_t    wb_dat_i,
  output wb_data_t    wb_dat_o,
  output logic        wb_ack_o,
  input  logic        adc_clk_0_i,
  input  logic        adc_clk_90_i,
  input  adc_data_t   adc_data_i,
  input  logic        adc_sync_i,
  input  adc_oor_t    adc_outofrange_i,
  output logic        adc_ctrl_clk_o,
  output logic        adc_ctrl_data_o,
  output logic        adc_ctrl_strobe_n_o,
  output logic        adc_mode_o,    // interleave mode
  output logic        adc_ddrb_o
);

  twi_addr_t    twi_addr;
  twi_data_t    twi_data;
  logic         twi_start;
  logic         twi_busy;
  sample_t      fifo_rd_data;
  fifo_status_t fifo_status;
  logic         fifo_rd;
  logic         fifo_flush;
  logic         fifo_enable;
  logic         fifo_wr_en;
  sample_t      fifo_wr_data;

  iadc_wb_regs i_regs (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o, .adc_mode_o, .adc_ddrb_o,
    .twi_addr_o(twi_addr), .twi_data_o(twi_data), .twi_start_o(twi_start),
    .twi_busy_i(twi_busy), .fifo_data_i(fifo_rd_data), .fifo_status_i(fifo_status),
    .fifo_rd_o(fifo_rd), .fifo_flush_o(fifo_flush), .fifo_enable_o(fifo_enable)
  );

  iadc_twi_tx #(.TWI_DIV_W(TWI_DIV_W)) i_twi (
    .wb_clk_i, .wb_rst_i, .start_i(twi_start), .addr_i(twi_addr), .data_i(twi_data),
    .busy_o(twi_busy), .ctrl_clk_o(adc_ctrl_clk_o), .ctrl_data_o(adc_ctrl_data_o),
    .ctrl_strobe_n_o(adc_ctrl_strobe_n_o)
  );

  iadc_capture i_capture (
    .adc_clk_0_i, .adc_clk_90_i, .wb_rst_i, .adc_data_i, .adc_oor_i(adc_outofrange_i),
    .adc_sync_i, .enable_i(fifo_enable), .wr_en_o(fifo_wr_en), .wr_data_o(fifo_wr_data)
  );

  // bus reset is long enough to cover several adc clocks
  iadc_sample_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) i_fifo (
    .wr_clk_i(adc_clk_0_i), .wr_rst_i(wb_rst_i), .wr_en_i(fifo_wr_en),
    .wr_data_i(fifo_wr_data), .rd_clk_i(wb_clk_i), .rd_rst_i(wb_rst_i),
    .rd_en_i(fifo_rd), .flush_i(fifo_flush), .rd_data_o(fifo_rd_data),
    .status_o(fifo_status)
  );

endmodule

// File: hdl/iadc_wb_regs.sv
`timescale 1ns/1ps

module iadc_wb_regs
  import iadc_reg_pkg::*;
  import iadc_sample_pkg::*;
(
  input  logic         wb_clk_i,
  input  logic         wb_rst_i,
  input  logic         wb_cyc_i,
  input  logic         wb_stb_i,
  input  logic         wb_we_i,
  input  wb_sel_t      wb_sel_i,
  input  logic [31:0]  wb_adr_i,
  input  wb_data_t     wb_dat_i,
  output wb_data_t     wb_dat_o,
  output logic         wb_ack_o,
  output logic         adc_mode_o,
  output logic         adc_ddrb_o,
  output twi_addr_t    twi_addr_o,
  output twi_data_t    twi_data_o,
  output logic         twi_start_o,
  input  logic         twi_busy_i,
  input  sample_t      fifo_data_i,
  input  fifo_status_t fifo_status_i,
  output logic         fifo_rd_o,
  output logic         fifo_flush_o,
  output logic         fifo_enable_o
);

  reg_idx_t adr_idx;
  reg_idx_t rd_idx;     // held for the read mux until the next access
  logic     accept;
  logic     enable_q;

  assign adr_idx = reg_idx_t'(wb_adr_i[4:1]);
  assign accept  = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    // strobes drop back after one cycle
    wb_ack_o    <= 1'b0;
    adc_ddrb_o  <= 1'b0;
    twi_start_o <= 1'b0;
    fifo_rd_o   <= 1'b0;

    if (wb_rst_i) begin
      rd_idx        <= REG_RESET;
      adc_mode_o    <= 1'b0;
      twi_addr_o    <= '0;
      twi_data_o    <= '0;
      fifo_enable_o <= 1'b0;
      enable_q      <= 1'b0;
    end else begin
      enable_q <= fifo_enable_o;

      if (accept) begin
        wb_ack_o <= 1'b1;
        rd_idx   <= adr_idx;
        if (wb_we_i) begin
          case (adr_idx)
            REG_RESET:    adc_ddrb_o <= wb_sel_i[0];   // data path reset pulse
            REG_MODE: begin
              if (wb_sel_i[0]) adc_mode_o <= wb_dat_i[0];
            end
            REG_TWI_ADDR: begin
              if (wb_sel_i[0]) twi_addr_o <= wb_dat_i[2:0];
            end
            REG_TWI_DATA: begin
              if (wb_sel_i[1]) twi_data_o[15:8] <= wb_dat_i[15:8];
              if (wb_sel_i[0]) twi_data_o[7:0]  <= wb_dat_i[7:0];
            end
            REG_TWI_TX:   twi_start_o <= wb_sel_i[0];  // ignored downstream if busy
            REG_FIFO_ADV: fifo_rd_o   <= wb_sel_i[0] & wb_dat_i[0];
            REG_FIFO_CTRL: begin
              if (wb_sel_i[0]) fifo_enable_o <= wb_dat_i[0];
            end
            default: ;  // data windows and status are read only
          endcase
        end
      end
    end
  end

  // rising edge of enable empties the fifo
  assign fifo_flush_o = fifo_enable_o & ~enable_q;

  always_comb begin
    case (rd_idx)
      REG_RESET:       wb_dat_o = wb_data_t'(adc_ddrb_o);
      REG_MODE:        wb_dat_o = wb_data_t'(adc_mode_o);
      REG_TWI_ADDR:    wb_dat_o = wb_data_t'(twi_addr_o);
      REG_TWI_DATA:    wb_dat_o = twi_data_o;
      REG_TWI_TX:      wb_dat_o = wb_data_t'(twi_busy_i);
      REG_FIFODATA_4:  wb_dat_o = wb_data_t'(fifo_data_i[71:64]);   // sync and oor
      REG_FIFODATA_3:  wb_dat_o = fifo_data_i[63:48];
      REG_FIFODATA_2:  wb_dat_o = fifo_data_i[47:32];
      REG_FIFODATA_1:  wb_dat_o = fifo_data_i[31:16];
      REG_FIFODATA_0:  wb_dat_o = fifo_data_i[15:0];
      REG_FIFO_STATUS: wb_dat_o = wb_data_t'(fifo_status_i);
      REG_FIFO_CTRL:   wb_dat_o = wb_data_t'(fifo_enable_o);
      default:         wb_dat_o = '0;
    endcase
  end

endmodule

// File: iadc_controller.f
common/iadc_reg_pkg.sv
common/iadc_sample_pkg.sv
hdl/iadc_wb_regs.sv
twi/iadc_twi_tx.sv
capture/iadc_capture.sv
capture/iadc_sample_fifo.sv
hdl/iadc_controller.sv
sim/iadc_properties.sv
sim/iadc_tb.sv

// File: sim/iadc_properties.sv
`timescale 1ns/1ps

module iadc_properties #(
  parameter int FIFO_ADDR_W = 4
) (
  input logic                 wb_clk_i,
  input logic                 wb_rst_i,
  input logic                 wb_ack_o,
  input logic                 adc_ddrb_o,
  input logic                 adc_ctrl_clk_o,
  input logic                 adc_ctrl_strobe_n_o,
  input logic                 adc_clk_0_i,
  input logic                 fifo_wr_en,
  input logic                 wr_full,       // write side view
  input logic [FIFO_ADDR_W:0] wr_bin
);

  int failures = 0;

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o) else begin
    $error("wb_ack_o high for two cycles");
    failures++;
  end

  // serial clock parked high outside a frame
  clk_idle_high: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    adc_ctrl_strobe_n_o |-> adc_ctrl_clk_o) else begin
    $error("ctrl clock low with strobe_n high");
    failures++;
  end

  ddrb_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    adc_ddrb_o |=> !adc_ddrb_o) else begin
    $error("adc_ddrb_o longer than one cycle");
    failures++;
  end

  no_write_when_full: assert property (@(posedge adc_clk_0_i) disable iff (wb_rst_i)
    fifo_wr_en && wr_full |=> $stable(wr_bin)) else begin
    $error("fifo write landed while full");
    failures++;
  end

endmodule

bind iadc_controller iadc_properties #(.FIFO_ADDR_W(FIFO_ADDR_W)) i_props (
  .wb_clk_i, .wb_rst_i, .wb_ack_o, .adc_ddrb_o, .adc_ctrl_clk_o, .adc_ctrl_strobe_n_o,
  .adc_clk_0_i, .fifo_wr_en, .wr_full(i_fifo.wr_full), .wr_bin(i_fifo.wr_bin)
);

// File: sim/iadc_tb.sv
`timescale 1ns/1ps

module iadc_tb
  import iadc_reg_pkg::*;
  import iadc_sample_pkg::*;
();

  localparam int TWI_DIV_W   = 3;
  localparam int FIFO_ADDR_W = 4;
  localparam int DEPTH       = 2 ** FIFO_ADDR_W;
  localparam int ACK_LIMIT   = 8;
  // frames take ~200 cycles each, fifo passes a few thousand in all
  localparam int MAX_CYCLES  = 40000;
  localparam int ST_FULL     = 3;   // status bit positions
  localparam int ST_EMPTY    = 0;

  logic        wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  wb_sel_t     wb_sel_i;
  logic [31:0] wb_adr_i;
  wb_data_t    wb_dat_i, wb_dat_o;
  logic        adc_clk_0_i, adc_clk_90_i, adc_sync_i;
  adc_data_t   adc_data_i;
  adc_oor_t    adc_outofrange_i;
  logic        adc_ctrl_clk_o, adc_ctrl_data_o, adc_ctrl_strobe_n_o, adc_mode_o, adc_ddrb_o;

  logic [31:0] sample_cnt;
  int          errors, errors_at_start, tests_run, tests_failed, cycles, ddrb_cycles;
  int          prop_failures;
  string       test_name;
  bit          twi_bits [$];
  string       name_q [$];
  sample_t     got_q [$];
  sample_t     exp_q [$];

  iadc_controller #(.TWI_DIV_W(TWI_DIV_W), .FIFO_ADDR_W(FIFO_ADDR_W)) i_dut (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    adc_clk_0_i = 1'b0;
    forever #14 adc_clk_0_i = ~adc_clk_0_i;
  end

  initial begin
    adc_clk_90_i = 1'b0;
    #7;   // quarter period behind clk_0
    forever #14 adc_clk_90_i = ~adc_clk_90_i;
  end

  // adc model, counter on the data pins, oor from its low bits
  initial begin
    sample_cnt       = '0;
    adc_sync_i       = 1'b0;
    adc_data_i       = '0;
    adc_outofrange_i = '0;
    forever begin
      @(posedge adc_clk_0_i);
      #2;
      sample_cnt       = sample_cnt + 32'd1;
      adc_data_i       = {sample_cnt, ~sample_cnt};
      adc_outofrange_i = sample_cnt[3:0];
    end
  end

  // expected word for counter value c, sync never set
  function automatic sample_t ref_sample(logic [31:0] c);
    return {4'b0000, c[3:0], c, c ^ 32'hffff_ffff};
  endfunction

  always @(posedge wb_clk_i) begin
    #1;
    if (adc_ddrb_o === 1'b1) ddrb_cycles++;
  end

  // serial monitor
  always @(posedge adc_ctrl_clk_o) begin
    #1;
    if (adc_ctrl_strobe_n_o === 1'b0) twi_bits.push_back(adc_ctrl_data_o);
  end

  // compare process
  always @(negedge wb_clk_i) begin
    string   name;
    sample_t got;
    sample_t exp;
    while (got_q.size() > 0) begin
      name = name_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      assert (got === exp) else begin
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles", cycles);
    $display("Some tests failed");
    $finish;
  end

  task automatic expect_sample(string name, sample_t got, sample_t exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  task automatic expect_word(string name, wb_data_t got, wb_data_t exp);
    expect_sample(name, {56'b0, got}, {56'b0, exp});
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic wb_access(bit we, reg_idx_t idx, wb_data_t data, wb_sel_t sel,
                           output wb_data_t rdata);
    int n;
    @(posedge wb_clk_i);
    #2;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = {27'b0, idx, 1'b0};   // register index on adr[4:1]
    wb_dat_i = data;
    n = 0;
    do begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end while (wb_ack_o !== 1'b1 && n < ACK_LIMIT);
    check_true(wb_ack_o === 1'b1 && n == 1,
               $sformatf("no ack one cycle after access to register %0d", idx));
    rdata = wb_dat_o;
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(reg_idx_t idx, wb_data_t data, wb_sel_t sel = 2'b11);
    wb_data_t ignored;
    wb_access(1'b1, idx, data, sel, ignored);
  endtask

  task automatic reg_read(reg_idx_t idx, output wb_data_t data);
    wb_access(1'b0, idx, 16'h0000, 2'b11, data);
  endtask

  task automatic wait_status(int bit_idx, bit level, string what);
    wb_data_t st;
    int       n;
    n = 0;
    do begin
      reg_read(REG_FIFO_STATUS, st);
      n++;
    end while (st[bit_idx] !== level && n < 200);
    check_true(st[bit_idx] === level, what);
  endtask

  // five windows then advance
  task automatic read_sample(output sample_t s);
    wb_data_t w [5];
    for (int i = 0; i < 5; i++) begin
      reg_read(reg_idx_t'(REG_FIFODATA_4 + i), w[i]);
    end
    expect_word("fifodata_4 upper byte", {8'h00, w[0][15:8]}, 16'h0000);
    s = {w[0][7:0], w[1], w[2], w[3], w[4]};
    reg_write(REG_FIFO_ADV, 16'h0001);
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    repeat (2) @(negedge wb_clk_i);   // let the compare queue drain
    if (i_dut.i_props.failures != prop_failures) begin
      errors        = errors + i_dut.i_props.failures - prop_failures;
      prop_failures = i_dut.i_props.failures;
    end
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    reg_idx_t                ctrl_regs [6];
    wb_data_t                rd;
    twi_addr_t               taddr;
    twi_data_t               tdata;
    logic [TWI_FRAME_W-1:0]  frame;
    sample_t                 s;
    logic [31:0]             first_cnt;
    int                      n;

    void'($urandom(61803));
    ctrl_regs = '{REG_RESET, REG_MODE, REG_TWI_ADDR, REG_TWI_DATA, REG_TWI_TX, REG_FIFO_CTRL};
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_sel_i = '0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    ddrb_cycles   = 0;
    prop_failures = 0;
    repeat (16) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;

    start_test("register reset and readback");
    foreach (ctrl_regs[i]) begin
      reg_read(ctrl_regs[i], rd);
      expect_word($sformatf("wb_dat_o reg %0d", ctrl_regs[i]), rd, 16'h0000);
    end
    reg_read(REG_FIFO_STATUS, rd);
    expect_word("fifo_status", rd, 16'h0003);   // empty, almost empty
    reg_write(REG_MODE, 16'h0001);
    reg_read(REG_MODE, rd);
    expect_word("adc_mode", rd, 16'h0001);
    check_true(adc_mode_o === 1'b1, "adc_mode_o pin does not follow the mode register");
    reg_write(REG_TWI_ADDR, 16'hfffd);
    reg_read(REG_TWI_ADDR, rd);
    expect_word("twi_addr", rd, 16'h0005);
    reg_write(REG_TWI_DATA, 16'ha5c3);
    reg_write(REG_TWI_DATA, 16'h3c7e, 2'b10);
    reg_read(REG_TWI_DATA, rd);
    expect_word("twi_data", rd, 16'h3cc3);
    reg_write(REG_TWI_DATA, 16'h1234, 2'b01);
    reg_read(REG_TWI_DATA, rd);
    expect_word("twi_data", rd, 16'h3c34);
    reg_write(REG_MODE, 16'h0000, 2'b10);   // upper byte only, mode kept
    reg_read(REG_MODE, rd);
    expect_word("adc_mode", rd, 16'h0001);
    end_test();

    start_test("data path reset strobe");
    ddrb_cycles = 0;
    reg_write(REG_RESET, 16'h0001, 2'b01);
    check_true(adc_ddrb_o === 1'b1, "adc_ddrb_o is not high together with the ack");
    reg_read(REG_RESET, rd);
    expect_word("reg_reset", rd, 16'h0000);
    expect_word("adc_ddrb_o cycles", 16'(ddrb_cycles), 16'h0001);
    end_test();

    start_test("three-wire frames");
    repeat (3) begin
      taddr = twi_addr_t'($urandom);
      tdata = twi_data_t'($urandom);
      frame = '0;
      twi_bits.delete();
      reg_write(REG_TWI_ADDR, {13'b0, taddr});
      reg_write(REG_TWI_DATA, tdata);
      reg_write(REG_TWI_TX, 16'h0001);
      reg_read(REG_TWI_TX, rd);
      expect_word("twi_busy", rd, 16'h0001);
      n = 0;
      do begin
        reg_read(REG_TWI_TX, rd);
        n++;
      end while (rd !== 16'h0000 && n < 200);
      check_true(rd === 16'h0000, "three-wire frame did not finish");
      check_true(adc_ctrl_strobe_n_o === 1'b1, "strobe_n did not return high after the frame");
      check_true(twi_bits.size() >= TWI_FRAME_W,
                 $sformatf("only %0d serial bits seen in the frame", twi_bits.size()));
      for (int i = 0; i < TWI_FRAME_W && i < twi_bits.size(); i++) begin
        frame[TWI_FRAME_W-1-i] = twi_bits[i];   // msb first on the wire
      end
      expect_sample("adc_ctrl_data_o frame", {53'b0, frame}, {53'b0, taddr, tdata});
    end
    end_test();

    start_test("fifo sample order");
    reg_write(REG_FIFO_CTRL, 16'h0001);
    wait_status(ST_EMPTY, 1'b0, "no sample reached the fifo after enable");
    for (int i = 0; i < DEPTH; i++) begin
      read_sample(s);
      if (i == 0) first_cnt = s[63:32];
      expect_sample("fifo sample", s, ref_sample(first_cnt + 32'(i)));
    end
    end_test();

    start_test("fifo status flags and flush");
    wait_status(ST_FULL, 1'b1, "fifo never reported full");
    reg_read(REG_FIFO_STATUS, rd);
    expect_word("fifo_status", rd, 16'h000c);
    reg_write(REG_FIFO_CTRL, 16'h0000);
    repeat (10) @(posedge wb_clk_i);   // last writes cross over
    n = 0;
    do begin
      reg_write(REG_FIFO_ADV, 16'h0001);
      reg_read(REG_FIFO_STATUS, rd);
      n++;
    end while (rd[ST_EMPTY] !== 1'b1 && n < 2 * DEPTH);
    expect_word("fifo_status", rd, 16'h0003);
    // refill, stop, and re-enable with the fifo still full
    reg_write(REG_FIFO_CTRL, 16'h0001);
    wait_status(ST_FULL, 1'b1, "fifo did not refill");
    reg_write(REG_FIFO_CTRL, 16'h0000);
    repeat (10) @(posedge wb_clk_i);
    reg_write(REG_FIFO_CTRL, 16'h0001);
    reg_read(REG_FIFO_STATUS, rd);
    expect_word("fifo_status", rd, 16'h0003);
    reg_write(REG_FIFO_CTRL, 16'h0000);
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: twi/iadc_twi_tx.sv
`timescale 1ns/1ps

module iadc_twi_tx
  import iadc_reg_pkg::*;
#(
  parameter int TWI_DIV_W = 7
) (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  logic      start_i,
  input  twi_addr_t addr_i,
  input  twi_data_t data_i,
  output logic      busy_o,
  output logic      ctrl_clk_o,
  output logic      ctrl_data_o,
  output logic      ctrl_strobe_n_o
);

  // frame slots, each one divider wrap long
  localparam logic [4:0] SLOT_IDLE   = 5'd0;
  localparam logic [4:0] SLOT_WAIT   = 5'd1;   // gives the first bit a full clock
  localparam logic [4:0] SLOT_FIRST  = 5'd2;
  localparam logic [4:0] SLOT_COMMIT = 5'(TWI_FRAME_W + 2);
  localparam logic [4:0] SLOT_END    = 5'(TWI_FRAME_W + 3);

  logic [TWI_DIV_W-1:0]   div_cnt;
  logic                   div_wrap;
  logic [4:0]             progress;
  logic [TWI_FRAME_W-1:0] shift_q;

  assign div_wrap = &div_cnt;   // serial clock falls here

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      div_cnt  <= '0;
      progress <= SLOT_IDLE;
      shift_q  <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;   // free running

      if (progress == SLOT_IDLE) begin
        if (start_i) begin
          progress <= SLOT_WAIT;
          shift_q  <= {addr_i, data_i};
        end
      end else if (div_wrap) begin
        case (progress)
          SLOT_WAIT:   progress <= SLOT_FIRST;
          SLOT_COMMIT: progress <= SLOT_END;
          SLOT_END:    progress <= SLOT_IDLE;
          default: begin
            // data slots, msb goes first
            shift_q  <= {shift_q[TWI_FRAME_W-2:0], 1'b0};
            progress <= progress + 5'd1;
          end
        endcase
      end
    end
  end

  assign busy_o = (progress != SLOT_IDLE);

  // clock only runs over the data and commit slots
  assign ctrl_clk_o = (progress >= SLOT_FIRST && progress <= SLOT_COMMIT) ?
                      div_cnt[TWI_DIV_W-1] : 1'b1;

  assign ctrl_strobe_n_o = (progress == SLOT_IDLE) || (progress == SLOT_END);
  assign ctrl_data_o     = shift_q[TWI_FRAME_W-1];

endmodule
